//--- tb.f
+incdir+.
cvt_pkg.sv
tile_writer.sv
tile_buffer.sv
transpose_reader.sv
ifmap_converter.sv
tb_clock.sv
tb_top.sv

//--- Bender.yml
package:
  name: ifmap_converter

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cvt_pkg.sv
      - tile_writer.sv
      - tile_buffer.sv
      - transpose_reader.sv
      - ifmap_converter.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock.sv
      - tb_top.sv

//--- tb_top.sv
// ----------------------------------------------------------
// testbench for the ifmap converter
// random tile stimulus with input gaps and output stalls,
// queue reference model, concurrent checks, watchdog
// ----------------------------------------------------------

`timescale 1ns/1ns
`include "cvt_settings.svh"

module tb_top
	import cvt_pkg::*;
();

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 3;
	localparam int TILES = 4;
	localparam int TOTAL = TILES * `CVT_TILE_WORDS;
	// words, two directions, four cycles of margin each, plus reset
	localparam int TIMEOUT_CYCLES = TOTAL * 2 * 4 + RESET_CYCLES;

	logic clk;
	logic reset;
	logic [`CVT_WORD_W-1:0] in_data = '0;
	logic in_empty_n = 1'b0;
	logic in_read;
	logic out_full_n = 1'b0;
	logic [`CVT_WORD_W-1:0] out_data;
	logic out_last;
	logic out_write;

	// reference model state
	logic [`CVT_WORD_W-1:0] in_q [$];
	int in_count = 0;
	int out_count = 0;
	logic holding = 1'b0;
	logic [`CVT_WORD_W-1:0] exp_data = '0;
	logic stalled = 1'b0;
	logic [`CVT_WORD_W-1:0] held_data = '0;
	logic held_last = 1'b0;

	// stimulus state
	logic [31:0] rng = 32'd93;
	int issued = 0;
	int stall_left = 0;

	int mismatch_errors = 0;
	int other_errors = 0;

	tb_clock #(
		.PERIOD(CLK_PERIOD),
		.RESET_CYCLES(RESET_CYCLES)
	) clock_i (
		.clk(clk),
		.reset(reset)
	);

	ifmap_converter dut_i (
		.clk(clk),
		.reset(reset),
		.in_data(in_data),
		.in_empty_n(in_empty_n),
		.in_read(in_read),
		.out_full_n(out_full_n),
		.out_data(out_data),
		.out_last(out_last),
		.out_write(out_write)
	);

	// 32-bit xorshift, shared by data and handshake timing
	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// ----------------------------------------------------------
	// reference transpose
	// ----------------------------------------------------------
	// output word n of the whole run, built from the queued input
	function automatic stream_word_u expect_word(int n);
		stream_word_u src;
		stream_word_u res;
		int base;
		int w;
		int col;
		int pix;
		int grp;
		int idx;
		base = (n / `CVT_TILE_WORDS) * `CVT_TILE_WORDS;
		w = n % `CVT_TILE_WORDS;
		// column word slowest, then pixel, group fastest
		col = w / (`CVT_LANES * `CVT_CH_GROUPS);
		pix = (w / `CVT_CH_GROUPS) % `CVT_LANES;
		grp = w % `CVT_CH_GROUPS;
		for (int k = 0; k < `CVT_LANES; k++) begin
			// input word of channel grp*8+k at column word col
			idx = base + (grp * `CVT_LANES + k) * `CVT_COL_WORDS + col;
			src.raw = (idx < in_q.size()) ? in_q[idx] : '0;
			// pixel p sits in lane 7-p, channel k goes to lane 7-k
			res.lanes[`CVT_LANES-1-k] = src.lanes[`CVT_LANES-1-pix];
		end
		return res;
	endfunction

	// ----------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------
	always @(posedge clk) begin : drive
		logic take;
		take = in_read && in_empty_n;
		if (reset) begin
			in_empty_n <= 1'b0;
			out_full_n <= 1'b0;
		end else begin
			// new head word only once the old one is taken
			if (take || !in_empty_n) begin
				if (issued < TOTAL && next_rand() % 4 != 0) begin
					in_data <= {next_rand(), next_rand()};
					in_empty_n <= 1'b1;
					issued = issued + 1;
				end else begin
					in_empty_n <= 1'b0;
				end
			end
			// sink stalls in phases of one to four cycles
			if (stall_left > 0) begin
				stall_left = stall_left - 1;
				out_full_n <= 1'b0;
			end else if (next_rand() % 8 == 0) begin
				stall_left = next_rand() % 4;
				out_full_n <= 1'b0;
			end else begin
				out_full_n <= 1'b1;
			end
		end
	end

	// ----------------------------------------------------------
	// model tracking
	// ----------------------------------------------------------
	always @(posedge clk) begin : track
		int next_out;
		next_out = out_count;
		if (!reset) begin
			if (in_read && in_empty_n) begin
				in_q.push_back(in_data);
				in_count <= in_count + 1;
				// tile complete, producer must wait for the drain
				if ((in_count + 1) % `CVT_TILE_WORDS == 0) begin
					holding <= 1'b1;
				end
			end
			if (out_write && out_full_n) begin
				next_out = out_count + 1;
				out_count <= next_out;
				if (next_out % `CVT_TILE_WORDS == 0) begin
					holding <= 1'b0;
				end
			end
		end
		exp_data <= expect_word(next_out);
		stalled <= !reset && out_write && !out_full_n;
		held_data <= out_data;
		held_last <= out_last;
	end

	// ----------------------------------------------------------
	// checks
	// ----------------------------------------------------------
	assert property (@(posedge clk) reset |-> !in_read && !out_write && !out_last)
	else begin
		other_errors++;
		$display("handshake outputs not low during reset at %0t", $time);
	end

	assert property (@(posedge clk) disable iff (reset)
		in_count == 0 |-> !out_write && !out_last)
	else begin
		other_errors++;
		$display("output active before any input word arrived at %0t", $time);
	end

	assert property (@(posedge clk) disable iff (reset)
		out_write && out_full_n |-> out_data == exp_data)
	else begin
		mismatch_errors++;
		$display("Mismatch at %0t: out_data expected %h got %h",
			$time, $sampled(exp_data), $sampled(out_data));
	end

	// end of tile on the 64th transfer only
	assert property (@(posedge clk) disable iff (reset)
		out_write && out_full_n |->
		out_last == (out_count % `CVT_TILE_WORDS == `CVT_TILE_WORDS - 1))
	else begin
		mismatch_errors++;
		$display("Mismatch at %0t: out_last expected %b got %b", $time,
			$sampled(out_count) % `CVT_TILE_WORDS == `CVT_TILE_WORDS - 1,
			$sampled(out_last));
	end

	assert property (@(posedge clk) disable iff (reset) stalled |-> out_data == held_data)
	else begin
		mismatch_errors++;
		$display("Mismatch at %0t: out_data expected %h got %h",
			$time, $sampled(held_data), $sampled(out_data));
	end

	assert property (@(posedge clk) disable iff (reset) stalled |-> out_last == held_last)
	else begin
		mismatch_errors++;
		$display("Mismatch at %0t: out_last expected %b got %b",
			$time, $sampled(held_last), $sampled(out_last));
	end

	assert property (@(posedge clk) disable iff (reset) holding |-> !in_read)
	else begin
		mismatch_errors++;
		$display("Mismatch at %0t: in_read expected 0 got %b", $time, $sampled(in_read));
	end

	assert property (@(posedge clk) disable iff (reset) holding |-> !(in_read && in_empty_n))
	else begin
		other_errors++;
		$display("input word taken while the buffer still held a tile at %0t", $time);
	end

	// never more output than input
	assert property (@(posedge clk) disable iff (reset)
		out_write && out_full_n |-> out_count < in_count)
	else begin
		other_errors++;
		$display("output transfer with no input word left to account for at %0t", $time);
	end

	// ----------------------------------------------------------
	// run control
	// ----------------------------------------------------------
	initial begin : run
		@(negedge reset);
		while (out_count < TOTAL) @(posedge clk);
		// room for any stray transfer to show up
		repeat (8) @(posedge clk);
		assert (in_count == TOTAL)
		else begin
			other_errors++;
			$display("%0d input words taken instead of %0d", in_count, TOTAL);
		end
		assert (out_count == TOTAL)
		else begin
			other_errors++;
			$display("%0d output words seen instead of %0d", out_count, TOTAL);
		end
		$display("errors: %0d mismatches, %0d other, %0d of %0d tiles out",
			mismatch_errors, other_errors, out_count / `CVT_TILE_WORDS, TILES);
		if (mismatch_errors == 0 && other_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin : watchdog
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("run did not finish in %0d cycles, %0d of %0d output words seen",
			TIMEOUT_CYCLES, out_count, TOTAL);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- tb_clock.sv
// ----------------------------------------------------------
// testbench clock and reset source
// free-running clock, reset held for a fixed cycle count
// ----------------------------------------------------------

`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD = 10,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// release on a clock edge, like the rest of the stimulus
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

//--- ifmap_converter.sv
// ----------------------------------------------------------
// ifmap converter top
// column-order tiles in, channel-order words out
// producer, one-tile buffer, transposing consumer
// ----------------------------------------------------------

`timescale 1ns/1ns
`include "cvt_settings.svh"

module ifmap_converter
	import cvt_pkg::*;
(
	input  logic clk,
	input  logic reset,
	// input stream, eight pixels of one channel per word
	input  logic [`CVT_WORD_W-1:0] in_data,
	input  logic in_empty_n,
	output logic in_read,
	// output stream, one pixel of eight channels per word
	input  logic out_full_n,
	output logic [`CVT_WORD_W-1:0] out_data,
	output logic out_last,
	output logic out_write
);

	// producer to buffer
	logic wr_en;
	logic [`CVT_ADDR_W-1:0] wr_addr;
	stream_word_u wr_data;
	logic fill_done;

	// buffer to consumer
	logic tile_valid;
	logic [$clog2(`CVT_COL_WORDS)-1:0] rd_col;
	logic [$clog2(`CVT_CH_GROUPS)-1:0] rd_group;
	stream_word_u rd_words [0:`CVT_LANES-1];
	logic drain_done;

	tile_writer writer_i (
		.clk(clk),
		.reset(reset),
		.in_data(in_data),
		.in_empty_n(in_empty_n),
		.in_read(in_read),
		.tile_valid(tile_valid),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.fill_done(fill_done)
	);

	tile_buffer buffer_i (
		.clk(clk),
		.reset(reset),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.fill_done(fill_done),
		.rd_col(rd_col),
		.rd_group(rd_group),
		.rd_words(rd_words),
		.drain_done(drain_done),
		.tile_valid(tile_valid)
	);

	transpose_reader reader_i (
		.clk(clk),
		.reset(reset),
		.tile_valid(tile_valid),
		.rd_words(rd_words),
		.rd_col(rd_col),
		.rd_group(rd_group),
		.drain_done(drain_done),
		.out_full_n(out_full_n),
		.out_data(out_data),
		.out_last(out_last),
		.out_write(out_write)
	);

endmodule

//--- transpose_reader.sv
// ----------------------------------------------------------
// tile consumer
// walks the stored tile by column word, pixel and channel
// group, transposes bytes and drives the output stream
// ----------------------------------------------------------

`timescale 1ns/1ns
`include "cvt_settings.svh"

module transpose_reader
	import cvt_pkg::*;
(
	input  logic clk,
	input  logic reset,
	// buffer side
	input  logic tile_valid,
	input  stream_word_u rd_words [0:`CVT_LANES-1],
	output logic [$clog2(`CVT_COL_WORDS)-1:0] rd_col,
	output logic [$clog2(`CVT_CH_GROUPS)-1:0] rd_group,
	output logic drain_done,
	// output stream, FIFO style
	input  logic out_full_n,
	output stream_word_u out_data,
	output logic out_last,
	output logic out_write
);

	localparam int PIX_W = $clog2(`CVT_LANES);
	localparam int COL_W = $clog2(`CVT_COL_WORDS);
	localparam int GRP_W = $clog2(`CVT_CH_GROUPS);

	// nested counters, group fastest, column word slowest
	logic [GRP_W-1:0] grp_cnt;
	logic [PIX_W-1:0] pix_cnt;
	logic [COL_W-1:0] col_cnt;
	logic grp_wrap;
	logic pix_wrap;
	logic col_wrap;
	logic last_pos;
	// all 64 words of this tile went into the output register
	logic tile_loaded;
	logic load;
	logic out_xfer;
	logic [PIX_W-1:0] lane_sel;
	stream_word_u packed_word;

	assign grp_wrap = (grp_cnt == GRP_W'(`CVT_CH_GROUPS - 1));
	assign pix_wrap = (pix_cnt == PIX_W'(`CVT_LANES - 1));
	assign col_wrap = (col_cnt == COL_W'(`CVT_COL_WORDS - 1));
	assign last_pos = grp_wrap & pix_wrap & col_wrap;

	assign out_xfer = out_write & out_full_n;
	// register empty or emptying this cycle, and words left in the tile
	assign load = tile_valid & ~tile_loaded & (~out_write | out_full_n);
	assign drain_done = out_xfer & out_last;

	assign rd_col = col_cnt;
	assign rd_group = grp_cnt;

	// ----------------------------------------------------------
	// transpose
	// ----------------------------------------------------------
	// pixel p lives in lane 7-p of each channel word
	assign lane_sel = PIX_W'(`CVT_LANES - 1) - pix_cnt;

	// channel k of the group goes to lane 7-k
	always_comb begin
		for (int k = 0; k < `CVT_LANES; k++) begin
			packed_word.lanes[`CVT_LANES-1-k] = rd_words[k].lanes[lane_sel];
		end
	end

	// ----------------------------------------------------------
	// address walk
	// ----------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			grp_cnt <= '0;
			pix_cnt <= '0;
			col_cnt <= '0;
		end else if (load) begin
			grp_cnt <= grp_wrap ? '0 : grp_cnt + 1'b1;
			if (grp_wrap) begin
				pix_cnt <= pix_wrap ? '0 : pix_cnt + 1'b1;
				if (pix_wrap) begin
					col_cnt <= col_wrap ? '0 : col_cnt + 1'b1;
				end
			end
		end
	end

	// stop after the 64th word until the tile is handed back
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tile_loaded <= 1'b0;
		end else if (drain_done) begin
			tile_loaded <= 1'b0;
		end else if (load && last_pos) begin
			tile_loaded <= 1'b1;
		end
	end

	// ----------------------------------------------------------
	// output register
	// ----------------------------------------------------------
	// holds word and last under back-pressure
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			out_write <= 1'b0;
			out_last <= 1'b0;
		end else if (load) begin
			out_write <= 1'b1;
			out_last <= last_pos;
		end else if (out_xfer) begin
			out_write <= 1'b0;
			out_last <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			out_data <= packed_word;
		end
	end

endmodule

//--- tile_buffer.sv
// ----------------------------------------------------------
// single-tile storage
// word write port from the producer, eight-word group read
// for the consumer, tile-valid flag between the two
// ----------------------------------------------------------

`timescale 1ns/1ns
`include "cvt_settings.svh"

module tile_buffer
	import cvt_pkg::*;
(
	input  logic clk,
	input  logic reset,
	// write side
	input  logic wr_en,
	input  logic [`CVT_ADDR_W-1:0] wr_addr,
	input  stream_word_u wr_data,
	input  logic fill_done,
	// read side
	input  logic [$clog2(`CVT_COL_WORDS)-1:0] rd_col,
	input  logic [$clog2(`CVT_CH_GROUPS)-1:0] rd_group,
	output stream_word_u rd_words [0:`CVT_LANES-1],
	input  logic drain_done,
	// full tile present, owned by the consumer
	output logic tile_valid
);

	localparam int LANE_W = $clog2(`CVT_LANES);

	// word of channel ch, column word c at ch*4 + c
	stream_word_u mem [0:`CVT_TILE_WORDS-1];

	// ----------------------------------------------------------
	// storage
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// ----------------------------------------------------------
	// group read
	// ----------------------------------------------------------
	// one word from each channel of the group, same column word
	// address is {group, channel in group, column word}
	always_comb begin
		for (int k = 0; k < `CVT_LANES; k++) begin
			rd_words[k] = mem[{rd_group, LANE_W'(k), rd_col}];
		end
	end

	// ----------------------------------------------------------
	// ownership flag
	// ----------------------------------------------------------
	// set by the last write, cleared by the last output transfer
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tile_valid <= 1'b0;
		end else if (drain_done) begin
			tile_valid <= 1'b0;
		end else if (fill_done) begin
			tile_valid <= 1'b1;
		end
	end

endmodule

//--- tile_writer.sv
// ----------------------------------------------------------
// tile producer
// reads the channel-major input stream, one tile at a time,
// and writes each word to the tile buffer
// ----------------------------------------------------------

`timescale 1ns/1ns
`include "cvt_settings.svh"

module tile_writer
	import cvt_pkg::*;
(
	input  logic clk,
	input  logic reset,
	// input stream, FIFO style
	input  stream_word_u in_data,
	input  logic in_empty_n,
	output logic in_read,
	// buffer hand-back, high while the consumer owns the tile
	input  logic tile_valid,
	// buffer write port
	output logic wr_en,
	output logic [`CVT_ADDR_W-1:0] wr_addr,
	output stream_word_u wr_data,
	output logic fill_done
);

	// word counter, channel-major so it is the buffer address
	logic [`CVT_ADDR_W-1:0] word_cnt;
	logic xfer;
	logic tile_end;

	// a word moves when we read and the source is not empty
	assign xfer = in_read & in_empty_n;
	// last word of the tile, channel 15 column word 3
	assign tile_end = (word_cnt == `CVT_ADDR_W'(`CVT_TILE_WORDS - 1));

	// ----------------------------------------------------------
	// read request
	// ----------------------------------------------------------
	// drops on the last transfer so no 65th word is taken,
	// then waits for the consumer to release the buffer
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			in_read <= 1'b0;
		end else if (xfer && tile_end) begin
			in_read <= 1'b0;
		end else begin
			in_read <= ~tile_valid;
		end
	end

	// ----------------------------------------------------------
	// address counter
	// ----------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			word_cnt <= '0;
		end else if (xfer) begin
			// wrap for the next tile
			if (tile_end) begin
				word_cnt <= '0;
			end else begin
				word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	// write in the same cycle as the transfer
	assign wr_en = xfer;
	assign wr_addr = word_cnt;
	assign wr_data = in_data;
	// pulse with the final write, buffer flags the tile on this edge
	assign fill_done = xfer & tile_end;

endmodule

//--- cvt_pkg.sv
// ----------------------------------------------------------
// shared types for the ifmap converter
// stream word union, decoded by pixel or by channel
// ----------------------------------------------------------

`include "cvt_settings.svh"

package cvt_pkg;

	// ----------------------------------------------------------
	// stream word
	// ----------------------------------------------------------
	// input side: pixel j of one channel sits in lanes[7-j]
	// output side: channel g*8+k of one pixel sits in lanes[7-k]
	// lanes[7] is the most significant byte of raw
	typedef union packed {
		logic [`CVT_WORD_W-1:0] raw;
		logic [`CVT_LANES-1:0][`CVT_BYTE_W-1:0] lanes;
	} stream_word_u;

endpackage

//--- cvt_settings.svh
// ----------------------------------------------------------
// tile geometry for the ifmap column-to-channel converter
// stream word width, lanes, tile size, buffer address width
// ----------------------------------------------------------

`ifndef CVT_SETTINGS_SVH
`define CVT_SETTINGS_SVH

// one pixel per byte lane
`define CVT_BYTE_W      8
// byte lanes per word, also channels per output group
`define CVT_LANES       8
`define CVT_WORD_W      64

// tile is 16 channels by 4 column words of 8 pixels
`define CVT_TILE_CH     16
`define CVT_COL_WORDS   4
`define CVT_CH_GROUPS   2

// 64 words in, 64 words out
`define CVT_TILE_WORDS  64
`define CVT_ADDR_W      6

`endif
